// ==== dv/tbDatapath.sv ====
`timescale 1ns/1ps

`include "cpuDefs_defs.svh"

module tbDatapath;
    import cpuPkg::*;

    localparam int NUM_RANDOM      = 200;
    localparam int PROG_LEN        = NUM_RANDOM + 10;   // r1..r7 setup and a store/load pair
    localparam int WATCHDOG_CYCLES = 16 + 2 * PROG_LEN + 50;
    localparam logic [31:0] SEED   = 32'h3d604b46;

    // kinds 0..8 are ADDU SUBU AND OR XOR SLT SLTU SLL SRL and kind 9 is ADD (not decoded)
    localparam logic [5:0] FUNCTS [10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                                          6'h2a, 6'h2b, 6'h00, 6'h02, 6'h20};
    // kinds 10..16 are ADDIU ANDI ORI XORI LUI LW SW and kind 17 is a SPECIAL2 nop
    localparam logic [5:0] OPCODES [8] = '{6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f,
                                          6'h23, 6'h2b, 6'h1c};

    logic     clk = 1'b0;
    logic     reset_i;
    word_t    pcF_o;
    logic     instEnF_o;
    word_t    instrF_i;
    word_t    memAddrE_o;
    logic     memReadEnE_o;
    word_t    memRdataM_i;
    logic     memWriteEnM_o;
    word_t    memAddrM_o;
    word_t    memWdataM_o;
    word_t    debugWbPc_o;
    logic     debugWbRfWen_o;
    regAddr_t debugWbRfWnum_o;
    word_t    debugWbRfWdata_o;

    word_t    imem [256];
    word_t    dmem [16];
    word_t    modelRegs [32];
    word_t    modelMem [16];
    word_t    expPc [$];
    regAddr_t expNum [$];
    word_t    expData [$];
    word_t    fetchOff;
    word_t    rdataNext;
    logic [31:0] lfsr;
    int       progLen;
    int       resetEdges = 0;
    logic     seenCommit = 1'b0;
    int       valueErrors = 0;
    int       protocolErrors = 0;
    int       addrErrors = 0;
    int       missingErrors = 0;

    datapath datapath_inst (
        .clk(clk), .reset_i(reset_i), .pcF_o(pcF_o), .instEnF_o(instEnF_o),
        .instrF_i(instrF_i), .memAddrE_o(memAddrE_o), .memReadEnE_o(memReadEnE_o),
        .memRdataM_i(memRdataM_i), .memWriteEnM_o(memWriteEnM_o), .memAddrM_o(memAddrM_o),
        .memWdataM_o(memWdataM_o), .debugWbPc_o(debugWbPc_o),
        .debugWbRfWen_o(debugWbRfWen_o), .debugWbRfWnum_o(debugWbRfWnum_o),
        .debugWbRfWdata_o(debugWbRfWdata_o)
    );

    always #10 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t randBits(input int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic regAddr_t randReg();
        word_t v;
        v = randBits(3);    // r0..r7 keeps hazards dense
        return {2'b00, v[2:0]};
    endfunction

    function automatic word_t fillWord(input int idx);
        word_t addr;
        addr = word_t'(idx) << 2;
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
    endfunction

    // encodes one instruction and runs it on the in-order ISA model
    task automatic emit(input int kind, input regAddr_t rs, input regAddr_t rt,
                        input regAddr_t rd, input shamt_t sh, input logic [15:0] imm);
        word_t    a;
        word_t    b;
        word_t    addr;
        word_t    res;
        word_t    pc;
        regAddr_t dest;
        a    = modelRegs[rs];
        b    = modelRegs[rt];
        addr = a + {{16{imm[15]}}, imm};
        pc   = `CPU_RESET_PC + word_t'(4 * progLen);
        if (kind <= 9) imem[progLen] = {6'h00, rs, rt, rd, sh, FUNCTS[kind]};
        else imem[progLen] = {OPCODES[kind - 10], rs, rt, imm};
        case (kind)
            0:  res = a + b;
            1:  res = a - b;
            2:  res = a & b;
            3:  res = a | b;
            4:  res = a ^ b;
            5:  res = {31'b0, $signed(a) < $signed(b)};
            6:  res = {31'b0, a < b};
            7:  res = b << sh;
            8:  res = b >> sh;
            10: res = addr;                 // ADDIU uses the same sign-extended sum
            11: res = a & {16'h0000, imm};
            12: res = a | {16'h0000, imm};
            13: res = a ^ {16'h0000, imm};
            14: res = {imm, 16'h0000};
            15: res = modelMem[addr[5:2]];
            default: res = '0;
        endcase
        if (kind == 16) modelMem[addr[5:2]] = b;
        dest = (kind <= 9) ? rd : rt;
        if (kind <= 15 && kind != 9 && dest != 5'd0) begin
            modelRegs[dest] = res;
            expPc.push_back(pc);
            expNum.push_back(dest);
            expData.push_back(res);
        end
        progLen++;
    endtask

    // out-of-range fetches return the all-zero nop (SLL of r0)
    always_comb begin
        fetchOff = pcF_o - `CPU_RESET_PC;
        if (fetchOff < word_t'(4 * PROG_LEN)) instrF_i = imem[fetchOff[9:2]];
        else instrF_i = '0;
    end

    // data memory writes land before reads on the same edge
    always @(posedge clk) begin : dataMem
        int i;
        if (reset_i) begin
            for (i = 0; i < 16; i++) dmem[i] = fillWord(i);
        end else begin
            if (memWriteEnM_o === 1'b1) begin
                if (memAddrM_o[31:6] != '0) begin
                    $display("store to address %h at %0t is outside the data memory",
                             memAddrM_o, $time);
                    addrErrors++;
                end
                dmem[memAddrM_o[5:2]] = memWdataM_o;
            end
            if (memReadEnE_o === 1'b1) begin
                if (memAddrE_o[31:6] != '0) begin
                    $display("load from address %h at %0t is outside the data memory",
                             memAddrE_o, $time);
                    addrErrors++;
                end
                rdataNext = dmem[memAddrE_o[5:2]];
            end
        end
    end

    always @(negedge clk) memRdataM_i <= rdataNext;

    // bubbles out of reset keep the memory enables low until the first commit
    always @(posedge clk) begin
        if (!reset_i && !seenCommit) begin
            if ((memReadEnE_o | memWriteEnM_o) !== 1'b0) begin
                $display("a memory enable was active before the first commit at %0t", $time);
                protocolErrors++;
            end
            if (debugWbRfWen_o === 1'b1) seenCommit = 1'b1;
        end
    end

    always @(posedge clk) begin : commitCheck
        word_t    wantPc;
        regAddr_t wantNum;
        word_t    wantData;
        if (reset_i) begin
            // first edge only clears the stages
            if (resetEdges > 0 && (memReadEnE_o | memWriteEnM_o | debugWbRfWen_o) !== 1'b0) begin
                $display("a memory or register write enable was active in reset at %0t", $time);
                protocolErrors++;
            end
            resetEdges++;
        end else if (debugWbRfWen_o) begin
            if (expPc.size() == 0) begin
                $display("register write to r%0d at %0t came with nothing left to commit",
                         debugWbRfWnum_o, $time);
                protocolErrors++;
            end else begin
                wantPc   = expPc.pop_front();
                wantNum  = expNum.pop_front();
                wantData = expData.pop_front();
                if (debugWbPc_o !== wantPc || debugWbRfWnum_o !== wantNum ||
                    debugWbRfWdata_o !== wantData) begin
                    $display("error %0t: commit pc %h r%0d data %h, expected pc %h r%0d data %h",
                             $time, debugWbPc_o, debugWbRfWnum_o, debugWbRfWdata_o,
                             wantPc, wantNum, wantData);
                    valueErrors++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog expired, the program did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        word_t       sel;
        word_t       v;
        int          kind;
        int          i;
        regAddr_t    rs;
        regAddr_t    rt;
        regAddr_t    rd;
        shamt_t      sh;
        logic [15:0] imm;

        reset_i     = 1'b1;
        memRdataM_i = '0;
        lfsr        = SEED;
        progLen     = 0;
        for (i = 0; i < 256; i++) imem[i] = '0;
        for (i = 0; i < 32; i++) modelRegs[i] = '0;
        for (i = 0; i < 16; i++) modelMem[i] = fillWord(i);

        for (i = 1; i < 8; i++) begin
            v = randBits(16);
            emit(10, '0, regAddr_t'(i), '0, '0, v[15:0]);
        end

        // a load right behind a store to the same word, then a user of the load
        emit(16, '0, 5'd1, '0, '0, 16'h0010);
        emit(15, '0, 5'd2, '0, '0, 16'h0010);
        emit(0, 5'd2, 5'd1, 5'd3, '0, '0);

        for (i = 0; i < NUM_RANDOM; i++) begin
            sel  = randBits(5);
            kind = (sel < 18) ? int'(sel) : (sel < 24) ? 15 : (sel < 30) ? 16 : 10;
            rs   = randReg();
            rt   = randReg();
            rd   = randReg();
            v    = randBits(5);
            sh   = v[4:0];
            v    = randBits(16);
            imm  = v[15:0];
            if (kind == 15 || kind == 16) begin
                rs  = '0;               // base r0 and one of 16 words
                v   = randBits(4);
                imm = {10'd0, v[3:0], 2'b00};
            end
            if (kind == 7 || kind == 8 || kind == 14) rs = '0;
            if (kind < 7 || kind == 9) sh = '0;
            emit(kind, rs, rt, rd, sh, imm);
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        if (pcF_o !== `CPU_RESET_PC || instEnF_o !== 1'b1) begin
            $display("error %0t: first fetch pc %h enable %b, expected pc %h enable 1",
                     $time, pcF_o, instEnF_o, `CPU_RESET_PC);
            valueErrors++;
        end

        // run until fetch is well past the last instruction
        while (pcF_o < `CPU_RESET_PC + word_t'(4 * (PROG_LEN + 8))) @(negedge clk);
        if (expPc.size() != 0) begin
            $display("%0d register writes from the program never committed", expPc.size());
            missingErrors = expPc.size();
        end
        $display("errors: value %0d, protocol %0d, address %0d, missing %0d",
                 valueErrors, protocolErrors, addrErrors, missingErrors);
        if (valueErrors + protocolErrors + addrErrors + missingErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+include
src/cpuPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/hazardUnit.sv
src/alu.sv
src/datapath.sv
dv/tbDatapath.sv

// ==== include/cpuDefs_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data, address and instruction width
`define CPU_XLEN 32

// register number width
`define CPU_REG_AW 5

// size of the integer register file
`define CPU_NUM_REGS 32

// first fetch address out of reset (kseg1 boot vector)
`define CPU_RESET_PC 32'hbfc0_0000

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it into a log and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --top-module tbDatapath -f filelist.f -o simTbDatapath
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simTbDatapath > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
exit 0

// ==== src/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpuPkg::word_t  a_i,
    input  cpuPkg::word_t  b_i,
    input  cpuPkg::shamt_t shamt_i,
    input  cpuPkg::aluOp_t op_i,
    output cpuPkg::word_t  result_o
);
    import cpuPkg::*;

    word_t sum;
    word_t diff;
    logic  ltSigned;
    logic  ltUnsigned;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;

    // signs differ -> a is less when a is negative
    assign ltSigned   = (a_i[$bits(word_t)-1] != b_i[$bits(word_t)-1]) ?
                        a_i[$bits(word_t)-1] : diff[$bits(word_t)-1];
    assign ltUnsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = diff;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLT:  result_o = {{($bits(word_t)-1){1'b0}}, ltSigned};
            ALU_SLTU: result_o = {{($bits(word_t)-1){1'b0}}, ltUnsigned};
            ALU_SLL:  result_o = b_i << shamt_i;   // shifts act on rt
            ALU_SRL:  result_o = b_i >> shamt_i;
            ALU_LUI:  result_o = {b_i[15:0], 16'h0000};
            default:  result_o = sum;
        endcase
    end

endmodule

// ==== src/cpuPkg.sv ====
`include "cpuDefs_defs.svh"

package cpuPkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;     // data, address, instruction
    typedef logic [`CPU_REG_AW-1:0] regAddr_t;
    typedef logic [4:0]             shamt_t;

    // execute-stage operation
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } aluOp_t;

    // operand source picked by the bypass logic
    typedef enum logic [1:0] {
        FWD_NONE,   // register file value
        FWD_MEM,    // result of the instruction in memory
        FWD_WB      // result of the instruction in write-back
    } fwdSel_t;

endpackage

// ==== src/datapath.sv ====
`timescale 1ns/1ps

`include "cpuDefs_defs.svh"

module datapath (
    input  logic             clk,
    input  logic             reset_i,
    // fetch
    output cpuPkg::word_t    pcF_o,
    output logic             instEnF_o,
    input  cpuPkg::word_t    instrF_i,
    // data
    output cpuPkg::word_t    memAddrE_o,
    output logic             memReadEnE_o,
    input  cpuPkg::word_t    memRdataM_i,
    output logic             memWriteEnM_o,
    output cpuPkg::word_t    memAddrM_o,
    output cpuPkg::word_t    memWdataM_o,
    // debug
    output cpuPkg::word_t    debugWbPc_o,
    output logic             debugWbRfWen_o,
    output cpuPkg::regAddr_t debugWbRfWnum_o,
    output cpuPkg::word_t    debugWbRfWdata_o
);
    import cpuPkg::*;

    logic     stallFD;
    fwdSel_t  fwdA, fwdB;
    // decode
    word_t    instrD, pcD, rd1D, rd2D, immD;
    regAddr_t rsD, rtD, destD;
    aluOp_t   aluOpD;
    logic     signExtD, aluImmSelD, destIsRtD, regWriteEnD, memReadD, memWriteD;
    // execute
    word_t    pcE, rd1E, rd2E, immE, srcAE, rtValueE, srcBE, aluOutE;
    regAddr_t rsE, rtE, destE;
    shamt_t   shamtE;
    aluOp_t   aluOpE;
    logic     aluImmSelE, regWriteEnE, memReadE, memWriteE;
    // memory, write-back
    word_t    pcM, aluOutM, storeDataM, resultM, resultW;
    regAddr_t destM, destW;
    logic     regWriteEnM, memReadM, memWriteM, regWriteEnW;

    function automatic word_t bypass(fwdSel_t sel, word_t regVal, word_t memVal, word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // fetch
    always_ff @(posedge clk) begin
        if (reset_i) pcF_o <= `CPU_RESET_PC;
        else if (!stallFD) pcF_o <= pcF_o + 32'd4;
    end
    assign instEnF_o = ~stallFD;    // fetched word is dropped while stalled

    always_ff @(posedge clk) begin
        if (reset_i) instrD <= '0;  // all-zero word decodes as a nop
        else if (!stallFD) instrD <= instrF_i;
    end
    always_ff @(posedge clk) begin
        if (!stallFD) pcD <= pcF_o;
    end

    // decode
    assign rsD   = instrD[25:21];
    assign rtD   = instrD[20:16];
    assign destD = destIsRtD ? rtD : instrD[15:11];
    assign immD  = {{16{instrD[15] & signExtD}}, instrD[15:0]};

    instrDecoder instrDecoder_inst (
        .instr_i(instrD), .aluOp_o(aluOpD), .signExt_o(signExtD), .aluImmSel_o(aluImmSelD),
        .destIsRt_o(destIsRtD), .regWriteEn_o(regWriteEnD), .memRead_o(memReadD),
        .memWrite_o(memWriteD)
    );

    regFile regFile_inst (
        .clk(clk), .we_i(regWriteEnM), .waddr_i(destM), .wdata_i(resultM),
        .raddr1_i(rsD), .raddr2_i(rtD), .rdata1_o(rd1D), .rdata2_o(rd2D)
    );

    hazardUnit hazardUnit_inst (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
        .destE_i(destE), .destM_i(destM), .destW_i(destW),
        .regWriteEnE_i(regWriteEnE), .memReadE_i(memReadE),
        .regWriteEnM_i(regWriteEnM), .regWriteEnW_i(regWriteEnW),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .stallFD_o(stallFD)
    );

    // D/E, a stall turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (reset_i || stallFD) begin
            aluImmSelE  <= 1'b0;
            regWriteEnE <= 1'b0;
            memReadE    <= 1'b0;
            memWriteE   <= 1'b0;
        end else begin
            aluImmSelE  <= aluImmSelD;
            regWriteEnE <= regWriteEnD;
            memReadE    <= memReadD;
            memWriteE   <= memWriteD;
        end
    end
    always_ff @(posedge clk) begin
        pcE    <= pcD;
        rd1E   <= rd1D;
        rd2E   <= rd2D;
        immE   <= immD;
        rsE    <= rsD;
        rtE    <= rtD;
        destE  <= destD;
        shamtE <= instrD[10:6];
        aluOpE <= aluOpD;
    end

    // execute
    assign srcAE    = bypass(fwdA, rd1E, aluOutM, resultW);
    assign rtValueE = bypass(fwdB, rd2E, aluOutM, resultW);
    assign srcBE    = aluImmSelE ? immE : rtValueE;

    alu alu_inst (.a_i(srcAE), .b_i(srcBE), .shamt_i(shamtE), .op_i(aluOpE), .result_o(aluOutE));

    assign memAddrE_o   = srcAE + immE;     // own adder, off the alu path
    assign memReadEnE_o = memReadE;

    // E/M
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regWriteEnM <= 1'b0;
            memReadM    <= 1'b0;
            memWriteM   <= 1'b0;
        end else begin
            regWriteEnM <= regWriteEnE;
            memReadM    <= memReadE;
            memWriteM   <= memWriteE;
        end
    end
    always_ff @(posedge clk) begin
        pcM        <= pcE;
        aluOutM    <= aluOutE;
        storeDataM <= rtValueE;
        destM      <= destE;
        memAddrM_o <= memAddrE_o;
    end

    // memory
    assign memWriteEnM_o = memWriteM;
    assign memWdataM_o   = storeDataM;
    assign resultM       = memReadM ? memRdataM_i : aluOutM;

    assign debugWbPc_o      = pcM;
    assign debugWbRfWen_o   = regWriteEnM;
    assign debugWbRfWnum_o  = destM;
    assign debugWbRfWdata_o = resultM;

    // M/W, kept only as a bypass source
    always_ff @(posedge clk) begin
        if (reset_i) regWriteEnW <= 1'b0;
        else regWriteEnW <= regWriteEnM;
    end
    always_ff @(posedge clk) begin
        destW   <= destM;
        resultW <= resultM;
    end

endmodule

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit (
    input  cpuPkg::regAddr_t rsD_i,
    input  cpuPkg::regAddr_t rtD_i,
    input  cpuPkg::regAddr_t rsE_i,
    input  cpuPkg::regAddr_t rtE_i,
    input  cpuPkg::regAddr_t destE_i,
    input  cpuPkg::regAddr_t destM_i,
    input  cpuPkg::regAddr_t destW_i,
    input  logic             regWriteEnE_i,
    input  logic             memReadE_i,
    input  logic             regWriteEnM_i,
    input  logic             regWriteEnW_i,
    output cpuPkg::fwdSel_t  fwdA_o,
    output cpuPkg::fwdSel_t  fwdB_o,
    output logic             stallFD_o
);
    import cpuPkg::*;

    // memory stage is younger, so it wins over write-back
    always_comb begin
        if (regWriteEnM_i && (destM_i == rsE_i)) fwdA_o = FWD_MEM;
        else if (regWriteEnW_i && (destW_i == rsE_i)) fwdA_o = FWD_WB;
        else fwdA_o = FWD_NONE;
    end

    always_comb begin
        if (regWriteEnM_i && (destM_i == rtE_i)) fwdB_o = FWD_MEM;
        else if (regWriteEnW_i && (destW_i == rtE_i)) fwdB_o = FWD_WB;
        else fwdB_o = FWD_NONE;
    end

    // load data only exists in memory, one bubble lets it reach write-back.
    // rt is compared even for I-type, costing at most a spare bubble
    assign stallFD_o = memReadE_i & regWriteEnE_i &
                       ((destE_i == rsD_i) || (destE_i == rtD_i));

endmodule

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  cpuPkg::word_t  instr_i,
    output cpuPkg::aluOp_t aluOp_o,
    output logic           signExt_o,
    output logic           aluImmSel_o,
    output logic           destIsRt_o,
    output logic           regWriteEn_o,
    output logic           memRead_o,
    output logic           memWrite_o
);
    import cpuPkg::*;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       writes;     // instruction produces a register result
    regAddr_t   dest;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign dest   = destIsRt_o ? instr_i[20:16] : instr_i[15:11];

    // r0 writes are dropped here so later stages never compare against zero
    assign regWriteEn_o = writes & (dest != '0);

    always_comb begin
        aluOp_o     = ALU_ADD;
        signExt_o   = 1'b0;
        aluImmSel_o = 1'b0;
        destIsRt_o  = 1'b0;
        writes      = 1'b0;
        memRead_o   = 1'b0;
        memWrite_o  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                writes = 1'b1;
                case (funct)
                    FN_ADDU: aluOp_o = ALU_ADD;
                    FN_SUBU: aluOp_o = ALU_SUB;
                    FN_AND:  aluOp_o = ALU_AND;
                    FN_OR:   aluOp_o = ALU_OR;
                    FN_XOR:  aluOp_o = ALU_XOR;
                    FN_SLT:  aluOp_o = ALU_SLT;
                    FN_SLTU: aluOp_o = ALU_SLTU;
                    FN_SLL:  aluOp_o = ALU_SLL;
                    FN_SRL:  aluOp_o = ALU_SRL;
                    default: writes = 1'b0;     // unsupported funct is a nop
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                aluImmSel_o = 1'b1;
                destIsRt_o  = 1'b1;
                writes      = 1'b1;
                signExt_o   = (opcode == OP_ADDIU) || (opcode == OP_LW);
                memRead_o   = (opcode == OP_LW);
                case (opcode)
                    OP_ANDI: aluOp_o = ALU_AND;
                    OP_ORI:  aluOp_o = ALU_OR;
                    OP_XORI: aluOp_o = ALU_XOR;
                    OP_LUI:  aluOp_o = ALU_LUI;
                    default: aluOp_o = ALU_ADD;
                endcase
            end
            OP_SW: begin
                aluImmSel_o = 1'b1;
                signExt_o   = 1'b1;
                memWrite_o  = 1'b1;
            end
            default: ;  // anything else falls through as a nop
        endcase
    end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps

`include "cpuDefs_defs.svh"

module regFile (
    input  logic              clk,
    input  logic              we_i,
    input  cpuPkg::regAddr_t  waddr_i,
    input  cpuPkg::word_t     wdata_i,
    input  cpuPkg::regAddr_t  raddr1_i,
    input  cpuPkg::regAddr_t  raddr2_i,
    output cpuPkg::word_t     rdata1_o,
    output cpuPkg::word_t     rdata2_o
);
    import cpuPkg::*;

    word_t regs [`CPU_NUM_REGS];

    // written at the end of the memory stage
    always_ff @(posedge clk) begin
        if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 is hardwired, the array entry is never trusted
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule
